// ==== design/frame_fifo_pkg.sv ====
// shared types for the frame receive path
//   axis_beat_t   one byte-wide stream beat with last and user flags
//   len_limits_t  minimum and maximum accepted frame length
//   configuration register addresses and limit reset values
package frame_fifo_pkg;

    // one stream beat, 10 bits
    typedef struct packed {
        // payload byte
        logic [7:0] data;
        // final beat of a frame
        logic       last;
        // bad frame marker, only meaningful on last
        logic       user;
    } axis_beat_t;

    // accepted frame length window, both bounds inclusive
    typedef struct packed {
        logic [15:0] min_len;
        logic [15:0] max_len;
    } len_limits_t;

    // configuration register map
    localparam logic [1:0] CFG_ADDR_MIN_LEN = 2'd0;
    localparam logic [1:0] CFG_ADDR_MAX_LEN = 2'd1;

    // limits after reset
    // max matches a standard ethernet payload
    localparam logic [15:0] LEN_MIN_RESET = 16'd1;
    localparam logic [15:0] LEN_MAX_RESET = 16'd1500;

endpackage

// ==== design/frame_len_cfg.sv ====
// frame length limit registers
// input domain, written by a single-cycle strobe
// holds min_len and max_len for the length checker

`timescale 1ns/1ps

module frame_len_cfg
    import frame_fifo_pkg::*;
(
    input  logic        input_clk,
    input  logic        input_rst,
    // write strobe, no back-pressure
    input  logic        cfg_wr,
    input  logic [1:0]  cfg_addr,
    input  logic [15:0] cfg_data,
    // current limits
    output len_limits_t limits
);

    // register file, two entries
    len_limits_t lim_q;

    always_ff @(posedge input_clk or posedge input_rst) begin
        if (input_rst) begin
            lim_q.min_len <= LEN_MIN_RESET;
            lim_q.max_len <= LEN_MAX_RESET;
        end else if (cfg_wr) begin
            // one register per strobe
            case (cfg_addr)
                CFG_ADDR_MIN_LEN: begin
                    lim_q.min_len <= cfg_data;
                end
                CFG_ADDR_MAX_LEN: begin
                    lim_q.max_len <= cfg_data;
                end
                default: begin
                    // unmapped address, write ignored
                    lim_q <= lim_q;
                end
            endcase
        end
    end

    assign limits = lim_q;

    // firmware keeps the window well formed
    // order of min/max writes has to respect this
    a_limits_ordered: assert property (
        @(posedge input_clk) disable iff (input_rst)
        cfg_wr |=> (limits.min_len <= limits.max_len)
    );

endmodule

// ==== design/frame_len_check.sv ====
// frame length checker, input domain
// combinational pass-through of beat, valid and ready
// flags frames outside the configured length window via user
// counts length rejects

`timescale 1ns/1ps

module frame_len_check
    import frame_fifo_pkg::*;
(
    input  logic        input_clk,
    input  logic        input_rst,
    // limits from the config block
    input  len_limits_t limits,
    // upstream stream
    input  axis_beat_t  in_beat,
    input  logic        in_valid,
    output logic        in_ready,
    // downstream to the frame FIFO
    output axis_beat_t  fifo_beat,
    output logic        fifo_valid,
    input  logic        fifo_ready,
    // number of length rejects
    output logic [15:0] reject_count
);

    // beats already transferred in this frame
    logic [15:0] beat_cnt;
    // limits captured at the first beat
    len_limits_t frame_lim;
    // limits that apply to the current beat
    len_limits_t cur_lim;
    // length including the current beat, one extra bit
    logic [16:0] frame_len;
    logic        len_bad;
    logic        xfer;

    assign xfer = in_valid && fifo_ready;

    // first beat sees the live limits, later beats the captured copy
    assign cur_lim   = (beat_cnt == 16'd0) ? limits : frame_lim;
    assign frame_len = {1'b0, beat_cnt} + 17'd1;
    assign len_bad   = (frame_len < {1'b0, cur_lim.min_len}) ||
                       (frame_len > {1'b0, cur_lim.max_len});

    // handshake passes straight through
    assign in_ready   = fifo_ready;
    assign fifo_valid = in_valid;

    always_comb begin
        fifo_beat = in_beat;
        // verdict only on the last beat, upstream error kept
        fifo_beat.user = in_beat.user | (in_beat.last & len_bad);
    end

    // beat counter and reject counter
    always_ff @(posedge input_clk or posedge input_rst) begin
        if (input_rst) begin
            beat_cnt     <= '0;
            reject_count <= '0;
        end else if (xfer) begin
            if (in_beat.last) begin
                beat_cnt <= '0;
                // upstream user errors are not counted here
                if (len_bad) begin
                    reject_count <= reject_count + 16'd1;
                end
            end else begin
                beat_cnt <= beat_cnt + 16'd1;
            end
        end
    end

    // limit snapshot, so a write mid-frame has no effect
    always_ff @(posedge input_clk) begin
        if (xfer && (beat_cnt == 16'd0)) begin
            frame_lim <= limits;
        end
    end

    // a non-final beat must leave a nonzero count behind
    a_no_count_wrap: assert property (
        @(posedge input_clk) disable iff (input_rst)
        (xfer && !in_beat.last) |=> (beat_cnt != 16'd0)
    );

endmodule

// ==== design/frame_fifo_async.sv ====
// dual-clock frame FIFO
// a frame is committed on a last beat with user clear
// bad frames and frames larger than the buffer are rewound
// Gray-coded pointers crossed through three-stage synchronizers
// registered read output with valid/ready handshake

`timescale 1ns/1ps

module frame_fifo_async
    import frame_fifo_pkg::*;
#(
    parameter int ADDR_WIDTH     = 6,
    parameter bit DROP_WHEN_FULL = 1'b0
) (
    // write side
    input  logic       input_clk,
    input  logic       input_rst,
    input  axis_beat_t wr_beat,
    input  logic       wr_valid,
    output logic       wr_ready,
    // read side
    input  logic       output_clk,
    input  logic       output_rst,
    output axis_beat_t rd_beat,
    output logic       rd_valid,
    input  logic       rd_ready
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    function automatic logic [ADDR_WIDTH:0] bin2gray(input logic [ADDR_WIDTH:0] b);
        return b ^ (b >> 1);
    endfunction

    // storage, data and last only
    logic [8:0] mem [DEPTH];

    // write domain pointers
    // wr_ptr is the committed frame boundary, wr_ptr_cur the next free slot
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] wr_ptr_cur;
    logic [ADDR_WIDTH:0] wr_ptr_gray;
    logic [ADDR_WIDTH:0] wr_ptr_inc;
    logic [ADDR_WIDTH:0] wr_cur_gray;
    logic                drop_frame;

    // read domain pointers
    logic [ADDR_WIDTH:0] rd_ptr;
    logic [ADDR_WIDTH:0] rd_ptr_gray;
    logic [ADDR_WIDTH:0] rd_ptr_inc;
    logic [8:0]          rd_word;

    // synchronizer chains, index 2 is the last stage
    logic [2:0][ADDR_WIDTH:0] wr_gray_sync;
    logic [2:0][ADDR_WIDTH:0] rd_gray_sync;

    logic full;
    logic full_cur;
    logic empty;
    logic discard;
    logic write;
    logic store;
    logic read;

    assign wr_ptr_inc  = wr_ptr_cur + 1'b1;
    assign wr_cur_gray = bin2gray(wr_ptr_cur);
    assign rd_ptr_inc  = rd_ptr + 1'b1;

    // no free slot for the frame in progress
    // Gray form of a one-lap difference, top two bits inverted
    assign full = (wr_cur_gray[ADDR_WIDTH:ADDR_WIDTH-1] ==
                   ~rd_gray_sync[2][ADDR_WIDTH:ADDR_WIDTH-1]) &&
                  (wr_cur_gray[ADDR_WIDTH-2:0] == rd_gray_sync[2][ADDR_WIDTH-2:0]);

    // current frame alone fills the whole buffer
    assign full_cur = (wr_ptr_cur[ADDR_WIDTH] != wr_ptr[ADDR_WIDTH]) &&
                      (wr_ptr_cur[ADDR_WIDTH-1:0] == wr_ptr[ADDR_WIDTH-1:0]);

    // only committed frames are visible to the reader
    assign empty = (rd_ptr_gray == wr_gray_sync[2]);

    // oversize frames are always swallowed, so a huge frame cannot deadlock
    assign wr_ready = DROP_WHEN_FULL | ~full | full_cur | drop_frame;
    assign write    = wr_valid && wr_ready;
    assign discard  = full || full_cur || drop_frame;
    assign store    = write && !discard;

    // write pointer control
    always_ff @(posedge input_clk or posedge input_rst) begin
        if (input_rst) begin
            wr_ptr      <= '0;
            wr_ptr_cur  <= '0;
            wr_ptr_gray <= '0;
            drop_frame  <= 1'b0;
        end else if (write) begin
            if (discard) begin
                // swallow the rest of the frame, rewind at its end
                if (wr_beat.last) begin
                    wr_ptr_cur <= wr_ptr;
                    drop_frame <= 1'b0;
                end else begin
                    drop_frame <= 1'b1;
                end
            end else if (wr_beat.last && wr_beat.user) begin
                // bad frame, forget everything since the last commit
                wr_ptr_cur <= wr_ptr;
            end else if (wr_beat.last) begin
                // good frame, publish the new boundary
                wr_ptr_cur  <= wr_ptr_inc;
                wr_ptr      <= wr_ptr_inc;
                wr_ptr_gray <= bin2gray(wr_ptr_inc);
            end else begin
                wr_ptr_cur <= wr_ptr_inc;
            end
        end
    end

    // memory write port
    always_ff @(posedge input_clk) begin
        if (store) begin
            mem[wr_ptr_cur[ADDR_WIDTH-1:0]] <= {wr_beat.last, wr_beat.data};
        end
    end

    // read pointer into the write domain
    always_ff @(posedge input_clk or posedge input_rst) begin
        if (input_rst) begin
            rd_gray_sync <= '0;
        end else begin
            rd_gray_sync <= {rd_gray_sync[1:0], rd_ptr_gray};
        end
    end

    // committed write pointer into the read domain
    always_ff @(posedge output_clk or posedge output_rst) begin
        if (output_rst) begin
            wr_gray_sync <= '0;
        end else begin
            wr_gray_sync <= {wr_gray_sync[1:0], wr_ptr_gray};
        end
    end

    // refill the output register when empty or being taken
    assign read = (rd_ready || !rd_valid) && !empty;

    always_ff @(posedge output_clk or posedge output_rst) begin
        if (output_rst) begin
            rd_ptr      <= '0;
            rd_ptr_gray <= '0;
            rd_valid    <= 1'b0;
        end else begin
            if (read) begin
                rd_ptr      <= rd_ptr_inc;
                rd_ptr_gray <= bin2gray(rd_ptr_inc);
            end
            if (rd_ready || !rd_valid) begin
                rd_valid <= !empty;
            end
        end
    end

    // output register
    always_ff @(posedge output_clk) begin
        if (read) begin
            rd_word <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end
    end

    always_comb begin
        rd_beat.data = rd_word[7:0];
        rd_beat.last = rd_word[8];
        // only good frames leave the FIFO
        rd_beat.user = 1'b0;
    end

    // read pointer only advances past committed, synchronized data
    a_no_read_empty: assert property (
        @(posedge output_clk) disable iff (output_rst)
        $changed(rd_ptr_gray) |-> $past(rd_ptr_gray != wr_gray_sync[2])
    );

    // stalled output holds its beat
    a_out_stable: assert property (
        @(posedge output_clk) disable iff (output_rst)
        (rd_valid && !rd_ready) |=> (rd_valid && $stable(rd_beat))
    );

endmodule

// ==== design/frame_rx_top.sv ====
// frame receive subsystem top level
// length limit registers, length checker and async frame FIFO
// input_clk side takes frames and config, output_clk side delivers frames

`timescale 1ns/1ps

module frame_rx_top
    import frame_fifo_pkg::*;
#(
    parameter int ADDR_WIDTH     = 6,
    parameter bit DROP_WHEN_FULL = 1'b0
) (
    input  logic        input_clk,
    input  logic        input_rst,
    input  logic        output_clk,
    input  logic        output_rst,
    // configuration strobe port
    input  logic        cfg_wr,
    input  logic [1:0]  cfg_addr,
    input  logic [15:0] cfg_data,
    // input stream
    input  axis_beat_t  in_beat,
    input  logic        in_valid,
    output logic        in_ready,
    // output stream, user always clear
    output axis_beat_t  out_beat,
    output logic        out_valid,
    input  logic        out_ready,
    // length reject counter, input domain
    output logic [15:0] reject_count
);

    len_limits_t limits;
    // checker to FIFO
    axis_beat_t  fifo_beat;
    logic        fifo_valid;
    logic        fifo_ready;

    frame_len_cfg u_cfg (
        .input_clk (input_clk),
        .input_rst (input_rst),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .limits    (limits)
    );

    frame_len_check u_check (
        .input_clk    (input_clk),
        .input_rst    (input_rst),
        .limits       (limits),
        .in_beat      (in_beat),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .fifo_beat    (fifo_beat),
        .fifo_valid   (fifo_valid),
        .fifo_ready   (fifo_ready),
        .reject_count (reject_count)
    );

    frame_fifo_async #(
        .ADDR_WIDTH     (ADDR_WIDTH),
        .DROP_WHEN_FULL (DROP_WHEN_FULL)
    ) u_fifo (
        .input_clk  (input_clk),
        .input_rst  (input_rst),
        .wr_beat    (fifo_beat),
        .wr_valid   (fifo_valid),
        .wr_ready   (fifo_ready),
        .output_clk (output_clk),
        .output_rst (output_rst),
        .rd_beat    (out_beat),
        .rd_valid   (out_valid),
        .rd_ready   (out_ready)
    );

endmodule

// ==== bench/frame_fifo_tb.sv ====
// testbench for the frame receive subsystem
// two clocks, resets, pattern file reader, config writes, frame driver
// random out_ready from a Galois LFSR, output monitor, per-test report

`timescale 1ns/1ps

module frame_fifo_tb
    import frame_fifo_pkg::*;
();

    localparam int ADDR_W = 6;
    localparam int DEPTH  = 2 ** ADDR_W;

    logic        input_clk;
    logic        output_clk;
    logic        input_rst;
    logic        output_rst;
    logic        cfg_wr;
    logic [1:0]  cfg_addr;
    logic [15:0] cfg_data;
    axis_beat_t  in_beat;
    logic        in_valid;
    logic        in_ready;
    axis_beat_t  out_beat;
    logic        out_valid;
    logic        out_ready;
    logic [15:0] reject_count;

    // one entry per pattern record
    string pat_name[$];
    string pat_outcome[$];
    int    pat_min[$];
    int    pat_max[$];
    int    pat_user[$];
    int    pat_len[$];
    int    pat_first[$];

    // bytes of kept frames still to come out
    logic [7:0] exp_data[$];
    logic       exp_last[$];
    logic [7:0] want_data;
    logic       want_last;

    string       cur_name;
    int          errors;
    int          test_errors;
    int          passed;
    int          failed;
    int          total_beats;
    int          cycle_count;
    int          cycle_limit;
    // length rejects so far, from the frame rules
    int          rejects_expected;
    bit          load_ok;
    logic [31:0] lfsr;

    frame_rx_top #(
        .ADDR_WIDTH     (ADDR_W),
        .DROP_WHEN_FULL (1'b0)
    ) DUT (
        .input_clk    (input_clk),
        .input_rst    (input_rst),
        .output_clk   (output_clk),
        .output_rst   (output_rst),
        .cfg_wr       (cfg_wr),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .in_beat      (in_beat),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_beat     (out_beat),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .reject_count (reject_count)
    );

    initial begin
        output_clk = 1'b0;
        forever #5 output_clk = ~output_clk;
    end

    // input side runs faster than the output side
    initial begin
        input_clk = 1'b0;
        forever #3.5 input_clk = ~input_clk;
    end

    initial begin
        input_rst = 1'b1;
        repeat (2) @(posedge input_clk);
        #1;
        input_rst = 1'b0;
    end

    initial begin
        output_rst = 1'b1;
        repeat (2) @(posedge output_clk);
        #1;
        output_rst = 1'b0;
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // one random bit per output cycle drives out_ready
    initial begin
        out_ready = 1'b0;
        lfsr      = 32'hf243_1ad0;
        wait (output_rst === 1'b0);
        forever begin
            @(posedge output_clk);
            #1;
            out_ready = lfsr[0];
            lfsr      = lfsr_next(lfsr);
        end
    end

    // sampled mid-cycle, transfer happens on the next rising edge
    always @(negedge output_clk) begin
        if (output_rst === 1'b0 && out_valid && out_ready) begin
            if (exp_data.size() == 0) begin
                $display("error in %s: output byte %02h arrived with none expected",
                         cur_name, out_beat.data);
                errors++;
                test_errors++;
            end else begin
                want_data = exp_data.pop_front();
                want_last = exp_last.pop_front();
                if (out_beat.data !== want_data) begin
                    $display("Mismatch in %s: data expected %02h actual %02h",
                             cur_name, want_data, out_beat.data);
                    errors++;
                    test_errors++;
                end
                if (out_beat.last !== want_last) begin
                    $display("Mismatch in %s: last on byte %02h expected %0b actual %0b",
                             cur_name, want_data, want_last, out_beat.last);
                    errors++;
                    test_errors++;
                end
                if (out_beat.user !== 1'b0) begin
                    $display("Mismatch in %s: user expected 0 actual %0b",
                             cur_name, out_beat.user);
                    errors++;
                    test_errors++;
                end
            end
        end
    end

    // watchdog, limit set once the patterns are known
    always @(posedge output_clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("error: run did not finish within %0d output cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task load_patterns();
        int                 fd;
        int                 n;
        int                 mn;
        int                 mx;
        int                 us;
        int                 ln;
        int                 fb;
        string              nm;
        string              oc;
        logic [8*128-1:0]   line;
        load_ok     = 1'b0;
        total_beats = 0;
        fd = $fopen("bench/frame_patterns.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open bench/frame_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                n = $fgets(line, fd);
                // comment lines fail the numeric fields and are skipped
                if (n > 0) begin
                    n = $sscanf(line, "%s %d %d %d %d %h %s", nm, mn, mx, us, ln, fb, oc);
                    if (n == 7) begin
                        pat_name.push_back(nm);
                        pat_min.push_back(mn);
                        pat_max.push_back(mx);
                        pat_user.push_back(us);
                        pat_len.push_back(ln);
                        pat_first.push_back(fb);
                        pat_outcome.push_back(oc);
                        total_beats += ln;
                    end
                end
            end
            $fclose(fd);
            load_ok = (pat_name.size() > 0);
            if (!load_ok) begin
                $display("error: pattern file holds no test records");
            end
        end
    endtask

    // max opened first so min never passes max on the way
    task write_limits(input int mn, input int mx);
        @(posedge input_clk);
        #1;
        cfg_wr   = 1'b1;
        cfg_addr = CFG_ADDR_MAX_LEN;
        cfg_data = 16'hffff;
        @(posedge input_clk);
        #1;
        cfg_addr = CFG_ADDR_MIN_LEN;
        cfg_data = mn[15:0];
        @(posedge input_clk);
        #1;
        cfg_addr = CFG_ADDR_MAX_LEN;
        cfg_data = mx[15:0];
        @(posedge input_clk);
        #1;
        cfg_wr = 1'b0;
    endtask

    // incrementing bytes, user only on the last beat
    task send_frame(input int first, input int len, input int user);
        int k;
        bit took;
        for (k = 0; k < len; k++) begin
            in_beat.data = 8'(first + k);
            in_beat.last = (k == len - 1);
            in_beat.user = (user != 0) && (k == len - 1);
            in_valid     = 1'b1;
            took         = 1'b0;
            while (!took) begin
                // in_ready only moves on input_clk edges
                @(negedge input_clk);
                took = in_ready;
                @(posedge input_clk);
                #1;
            end
        end
        in_valid = 1'b0;
        in_beat  = '0;
    endtask

    task report_test();
        if (test_errors == 0) begin
            passed++;
            $display("test %s passed", cur_name);
        end else begin
            failed++;
            $display("test %s failed with %0d errors", cur_name, test_errors);
        end
    endtask

    task run_test(input int i);
        int k;
        bit len_bad;
        bit keep;
        cur_name    = pat_name[i];
        test_errors = 0;
        // frame rules, length window then user flag then buffer size
        len_bad = (pat_len[i] < pat_min[i]) || (pat_len[i] > pat_max[i]);
        keep    = !len_bad && (pat_user[i] == 0) && (pat_len[i] <= DEPTH);
        if (keep != (pat_outcome[i] == "keep")) begin
            $display("error in %s: file outcome %s disagrees with the frame rules",
                     cur_name, pat_outcome[i]);
            errors++;
            test_errors++;
        end
        // only length rejects count, user errors do not
        rejects_expected += len_bad;
        if (pat_outcome[i] == "keep") begin
            for (k = 0; k < pat_len[i]; k++) begin
                exp_data.push_back(8'(pat_first[i] + k));
                exp_last.push_back(k == pat_len[i] - 1);
            end
        end
        write_limits(pat_min[i], pat_max[i]);
        send_frame(pat_first[i], pat_len[i], pat_user[i]);
        // counter has already stepped on the last-beat edge
        if (reject_count !== 16'(rejects_expected)) begin
            $display("Mismatch in %s: reject_count expected %0d actual %0d",
                     cur_name, rejects_expected, reject_count);
            errors++;
            test_errors++;
        end
        if (pat_outcome[i] == "keep") begin
            while (exp_data.size() != 0) begin
                @(posedge output_clk);
            end
        end else begin
            // quiet window, monitor flags any stray byte
            repeat (16) @(posedge output_clk);
        end
        report_test();
    endtask

    initial begin
        cfg_wr           = 1'b0;
        cfg_addr         = '0;
        cfg_data         = '0;
        in_beat          = '0;
        in_valid         = 1'b0;
        errors           = 0;
        passed           = 0;
        failed           = 0;
        cycle_count      = 0;
        cycle_limit      = 0;
        rejects_expected = 0;
        load_patterns();
        if (!load_ok) begin
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            cycle_limit = total_beats * 12 + 500;
            wait (input_rst === 1'b0 && output_rst === 1'b0);
            @(posedge input_clk);
            #1;
            cur_name    = "reset_state";
            test_errors = 0;
            if (out_valid !== 1'b0) begin
                $display("Mismatch in reset_state: out_valid expected 0 actual %0b",
                         out_valid);
                errors++;
                test_errors++;
            end
            // empty buffer takes beats right away
            if (in_ready !== 1'b1) begin
                $display("Mismatch in reset_state: in_ready expected 1 actual %0b",
                         in_ready);
                errors++;
                test_errors++;
            end
            if (reject_count !== 16'd0) begin
                $display("Mismatch in reset_state: reject_count expected 0 actual %0d",
                         reject_count);
                errors++;
                test_errors++;
            end
            report_test();
            for (int i = 0; i < pat_name.size(); i++) begin
                run_test(i);
            end
            $display("tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
            if (failed == 0 && errors == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== sim.f ====
design/frame_fifo_pkg.sv
design/frame_len_cfg.sv
design/frame_len_check.sv
design/frame_fifo_async.sv
design/frame_rx_top.sv
bench/frame_fifo_tb.sv

// ==== bench/frame_patterns.txt ====
# name  min_len  max_len  user  length  first_byte(hex)  outcome(keep|drop)
# bytes count up from first_byte and wrap at 8 bits, user marks the last beat
single_byte      1   1500  0   1  10  keep
short_keep       1   1500  0   8  20  keep
user_flag        1   1500  1   6  30  drop
too_short        4   32    0   3  40  drop
min_edge         4   32    0   4  48  keep
max_edge         4   32    0  32  50  keep
too_long         4   32    0  33  70  drop
buffer_fit       1   1500  0  64  80  keep
oversize         1   1500  0  70  00  drop
after_oversize   1   1500  0  12  c0  keep
user_short       10  20    1   3  90  drop
burst_a          2   100   0  40  11  keep
burst_b          2   100   0  50  55  keep
tight_window     16  16    0  16  e0  keep
tight_over       16  16    0  17  f0  drop
wrap_bytes       1   1500  0  24  f4  keep
